/* Bender.yml */
package:
  name: tpu_issue

export_include_dirs:
  - hw

sources:
  - hw/tpu_issue_pkg.sv
  - hw/ring_buff_ctrl.sv
  - hw/hazard_table.sv
  - hw/hazard_check.sv
  - hw/tpu_issue_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tpu_issue_asserts.sv
      - tb/tpu_issue_checker.sv
      - tb/tpu_issue_tb.sv

/* hw/hazard_check.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module hazard_check
	import tpu_issue_pkg::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic						i_req,
	input	instr_t						i_instr,
	input	row_t [`TPU_NUM_ENTRY-1:0]	i_rows,
	input	logic						i_full,
	input	issue_no_t					i_wr_no,
	output	logic						o_stall,
	output	logic						o_alloc,
	output	hazard_t					o_hazard,
	output	logic						o_issue,
	output	issue_t						o_issue_instr
);

	reg_id_t					dst_id;
	reg_id_t					src1_id;
	reg_id_t					src2_id;
	reg_id_t					src3_id;
	logic [`TPU_NUM_ENTRY-1:0]	raw_m;
	logic [`TPU_NUM_ENTRY-1:0]	war_m;
	logic [`TPU_NUM_ENTRY-1:0]	waw_m;
	logic [`TPU_NUM_ENTRY-1:0]	rar_m;
	hazard_t					haz;
	hazard_t					hazard_q;
	logic						issue_q;
	issue_t						issue_instr_q;

	// Live destination of a row equals id
	function automatic logic dst_hit(input row_t r, input reg_id_t id);
		return r.v_dst && (r.dst == id);
	endfunction

	// Any live source of a row equals id
	function automatic logic src_hit(input row_t r, input reg_id_t id);
		return (r.v_src1 && (r.src1 == id))
			|| (r.v_src2 && (r.src2 == id))
			|| (r.v_src3 && (r.src3 == id));
	endfunction

	assign dst_id	= {i_instr.is_vec, i_instr.dst};
	assign src1_id	= {i_instr.is_vec, i_instr.src1};
	assign src2_id	= {i_instr.is_vec, i_instr.src2};
	assign src3_id	= {i_instr.is_vec, i_instr.src3};

	always_comb begin
		for (int i = 0; i < `TPU_NUM_ENTRY; i++) begin
			raw_m[i] = (i_instr.v_src1 && dst_hit(i_rows[i], src1_id))
				|| (i_instr.v_src2 && dst_hit(i_rows[i], src2_id))
				|| (i_instr.v_src3 && dst_hit(i_rows[i], src3_id));
			war_m[i] = i_instr.v_dst && src_hit(i_rows[i], dst_id);
			waw_m[i] = i_instr.v_dst && dst_hit(i_rows[i], dst_id);
			// Shared sliced reads, reported only
			rar_m[i] = i_instr.slice && i_rows[i].slice
				&& ((i_instr.v_src1 && src_hit(i_rows[i], src1_id))
				|| (i_instr.v_src2 && src_hit(i_rows[i], src2_id))
				|| (i_instr.v_src3 && src_hit(i_rows[i], src3_id)));
		end
	end

	assign haz.raw	= |raw_m;
	assign haz.war	= |war_m;
	assign haz.waw	= |waw_m;
	assign haz.rar	= |rar_m;

	assign o_stall	= i_req && (haz.raw || haz.war || haz.waw || i_full);
	assign o_alloc	= i_req && !o_stall;

	always_ff @(posedge clock) begin
		if (reset) begin
			hazard_q	<= '0;
			issue_q		<= 1'b0;
		end else begin
			hazard_q	<= i_req ? haz : '0;	// Cleared with no request
			issue_q		<= o_alloc;
		end
	end

	always_ff @(posedge clock) begin
		if (o_alloc) begin
			issue_instr_q.instr		<= i_instr;
			issue_instr_q.issue_no	<= i_wr_no;
		end
	end

	assign o_hazard			= hazard_q;
	assign o_issue			= issue_q;
	assign o_issue_instr	= issue_instr_q;

endmodule

/* hw/hazard_table.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module hazard_table
	import tpu_issue_pkg::*;
(
	input	logic								clock,
	input	logic								reset,
	input	logic								i_alloc,
	input	issue_no_t							i_wr_no,
	input	instr_t								i_instr,
	input	logic								i_commit,
	input	issue_no_t							i_commit_no,
	output	row_t [`TPU_NUM_ENTRY-1:0]			o_rows,
	output	logic [`TPU_NUM_ENTRY-1:0]			o_live
);

	row_t [`TPU_NUM_ENTRY-1:0]	rows;
	logic [`TPU_NUM_ENTRY-1:0]	busy;	// Holds rows that have no operands
	row_t						new_row;
	logic						no_opnd;

	assign o_rows = rows;

	// Tag every index with the register file it belongs to
	always_comb begin
		new_row.v_dst	= i_instr.v_dst;
		new_row.v_src1	= i_instr.v_src1;
		new_row.v_src2	= i_instr.v_src2;
		new_row.v_src3	= i_instr.v_src3;
		new_row.slice	= i_instr.slice;
		new_row.dst		= {i_instr.is_vec, i_instr.dst};
		new_row.src1	= {i_instr.is_vec, i_instr.src1};
		new_row.src2	= {i_instr.is_vec, i_instr.src2};
		new_row.src3	= {i_instr.is_vec, i_instr.src3};
	end

	assign no_opnd = !(i_instr.v_dst || i_instr.v_src1 || i_instr.v_src2 || i_instr.v_src3);

	always_comb begin
		for (int i = 0; i < `TPU_NUM_ENTRY; i++) begin
			o_live[i] = busy[i] || rows[i].v_dst || rows[i].v_src1
				|| rows[i].v_src2 || rows[i].v_src3;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `TPU_NUM_ENTRY; i++) begin
				rows[i].v_dst	<= 1'b0;
				rows[i].v_src1	<= 1'b0;
				rows[i].v_src2	<= 1'b0;
				rows[i].v_src3	<= 1'b0;
			end
			busy <= '0;
		end else begin
			if (i_commit) begin
				rows[i_commit_no].v_dst		<= 1'b0;
				rows[i_commit_no].v_src1	<= 1'b0;
				rows[i_commit_no].v_src2	<= 1'b0;
				rows[i_commit_no].v_src3	<= 1'b0;
				busy[i_commit_no]			<= 1'b0;
			end
			// Allocation wins, a stale commit to this row is dropped
			if (i_alloc) begin
				rows[i_wr_no]	<= new_row;
				busy[i_wr_no]	<= no_opnd;
			end
		end
	end

endmodule

/* hw/ring_buff_ctrl.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module ring_buff_ctrl
	import tpu_issue_pkg::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic						i_alloc,
	input	logic [`TPU_NUM_ENTRY-1:0]	i_live,
	output	issue_no_t					o_wr_no,
	output	issue_no_t					o_rd_no,
	output	logic						o_full,
	output	logic						o_empty
);

	// One extra bit so the count can hold a full buffer
	localparam int CNT_W = $clog2(`TPU_NUM_ENTRY) + 1;

	issue_no_t			wr_ptr;
	issue_no_t			rd_ptr;
	logic [CNT_W-1:0]	count;
	logic				retire;

	assign o_wr_no	= wr_ptr;
	assign o_rd_no	= rd_ptr;
	assign o_full	= (count == CNT_W'(`TPU_NUM_ENTRY));
	assign o_empty	= (count == '0);

	// Oldest row leaves once it is committed
	assign retire	= !o_empty && !i_live[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
		end else begin
			if (i_alloc)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at the table depth
			if (retire)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({i_alloc, retire})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;	// Both or neither
			endcase
		end
	end

endmodule

/* hw/tpu_issue_defs.svh */
`ifndef TPU_ISSUE_DEFS_SVH
`define TPU_ISSUE_DEFS_SVH

// Rows in the hazard table, also the number of issue numbers
// Must stay a power of two so the ring pointers wrap on their own
`define TPU_NUM_ENTRY	8

// Register index width, without the scalar/vector flag
`define TPU_INDEX_W		5

`define TPU_IMM_W		16	// Immediate field
`define TPU_SLEN_W		4	// Slice length field

`endif

/* hw/tpu_issue_pkg.sv */
package tpu_issue_pkg;

`include "tpu_issue_defs.svh"

	typedef logic [`TPU_INDEX_W-1:0]			index_t;
	typedef logic [`TPU_INDEX_W:0]				reg_id_t;	// {is_vec, index}
	typedef logic [$clog2(`TPU_NUM_ENTRY)-1:0]	issue_no_t;	// Same as the row address
	typedef logic [`TPU_SLEN_W-1:0]				slen_t;

	// Request from the decoder
	typedef struct packed {
		logic					is_vec;
		logic					slice;
		slen_t					slice_len;
		logic					v_dst;
		logic					v_src1;
		logic					v_src2;
		logic					v_src3;
		index_t					dst;
		index_t					src1;
		index_t					src2;
		index_t					src3;
		logic [`TPU_IMM_W-1:0]	imm;
	} instr_t;

	// One hazard table row, flags are live until commit
	typedef struct packed {
		logic		v_dst;
		logic		v_src1;
		logic		v_src2;
		logic		v_src3;
		logic		slice;
		reg_id_t	dst;
		reg_id_t	src1;
		reg_id_t	src2;
		reg_id_t	src3;
	} row_t;

	typedef struct packed {
		logic	raw;
		logic	war;
		logic	waw;
		logic	rar;
	} hazard_t;

	typedef struct packed {
		instr_t		instr;
		issue_no_t	issue_no;
	} issue_t;

endpackage

/* hw/tpu_issue_top.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module tpu_issue_top
	import tpu_issue_pkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		i_req,
	input	instr_t		i_instr,
	input	logic		i_commit,
	input	issue_no_t	i_commit_no,
	output	logic		o_stall,
	output	logic		o_issue,
	output	issue_t		o_issue_instr,
	output	hazard_t	o_hazard,
	output	issue_no_t	o_rd_ptr
);

	logic						alloc;
	logic						full;
	issue_no_t					wr_no;
	row_t [`TPU_NUM_ENTRY-1:0]	rows;
	logic [`TPU_NUM_ENTRY-1:0]	live;

	hazard_check u_check (
		.clock			(clock),
		.reset			(reset),
		.i_req			(i_req),
		.i_instr		(i_instr),
		.i_rows			(rows),
		.i_full			(full),
		.i_wr_no		(wr_no),
		.o_stall		(o_stall),
		.o_alloc		(alloc),
		.o_hazard		(o_hazard),
		.o_issue		(o_issue),
		.o_issue_instr	(o_issue_instr)
	);

	hazard_table u_table (
		.clock			(clock),
		.reset			(reset),
		.i_alloc		(alloc),
		.i_wr_no		(wr_no),
		.i_instr		(i_instr),
		.i_commit		(i_commit),
		.i_commit_no	(i_commit_no),
		.o_rows			(rows),
		.o_live			(live)
	);

	// Oldest live number goes out to the commit side
	ring_buff_ctrl u_ring (
		.clock			(clock),
		.reset			(reset),
		.i_alloc		(alloc),
		.i_live			(live),
		.o_wr_no		(wr_no),
		.o_rd_no		(o_rd_ptr),
		.o_full			(full),
		.o_empty		()
	);

endmodule

/* tb.f */
+incdir+hw
hw/tpu_issue_pkg.sv
hw/ring_buff_ctrl.sv
hw/hazard_table.sv
hw/hazard_check.sv
hw/tpu_issue_top.sv
tb/tb_clock_gen.sv
tb/tpu_issue_asserts.sv
tb/tpu_issue_checker.sv
tb/tpu_issue_tb.sv

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output	logic	clock,
	output	logic	reset
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;	// 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* tb/tpu_issue_asserts.sv */
`timescale 1ns/1ps

module tpu_issue_asserts
	import tpu_issue_pkg::*;
(
	input	logic	clock,
	input	logic	reset,
	input	logic	i_req,
	input	instr_t	i_instr,
	input	logic	i_stall,
	input	logic	i_issue
);

	int fail_count = 0;	// Summed into the final result

	// Issue pulse only after an accepting edge
	a_issue_after_accept: assert property (@(posedge clock) disable iff (reset)
		i_issue |-> $past(i_req && !i_stall))
		else begin
			fail_count++;
			$error("o_issue pulsed without an accepted request one cycle before");
		end

	a_stall_needs_req: assert property (@(posedge clock) disable iff (reset)
		i_stall |-> i_req)
		else begin
			fail_count++;
			$error("o_stall is high while i_req is low");
		end

	// Upstream holds the request through a stall
	a_instr_held: assert property (@(posedge clock) disable iff (reset)
		i_stall |=> (i_req && $stable(i_instr)))
		else begin
			fail_count++;
			$error("request changed while o_stall was high");
		end

endmodule

/* tb/tpu_issue_checker.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module tpu_issue_checker
	import tpu_issue_pkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		i_req,
	input	instr_t		i_instr,
	input	logic		i_commit,
	input	issue_no_t	i_commit_no,
	input	logic		i_stall,
	input	logic		i_issue,
	input	issue_t		i_issue_instr,
	input	hazard_t	i_hazard,
	input	issue_no_t	i_rd_ptr,
	output	int			o_checks,
	output	int			o_errors
);

	row_t		sh_rows [`TPU_NUM_ENTRY];
	logic		sh_busy [`TPU_NUM_ENTRY];	// Operand-free rows
	issue_no_t	sh_wr;
	issue_no_t	sh_rd;
	int			sh_count;
	logic		exp_issue;
	issue_t		exp_issue_instr;
	hazard_t	exp_hazard;
	int			n_checks = 0;
	int			n_errors = 0;

	assign o_checks = n_checks;
	assign o_errors = n_errors;

	function automatic logic row_live(input int r);
		return sh_busy[r] || sh_rows[r].v_dst || sh_rows[r].v_src1
			|| sh_rows[r].v_src2 || sh_rows[r].v_src3;
	endfunction

	// Hazards of a request against the shadow rows, and the stall they cause
	function automatic hazard_t ref_check(input logic req, input instr_t ri, output logic stall);
		hazard_t	h;
		reg_id_t	d;
		reg_id_t	s [3];
		logic		vs [3];
		reg_id_t	rs [3];
		logic		rv [3];
		h = '0;
		d = {ri.is_vec, ri.dst};
		s = '{{ri.is_vec, ri.src1}, {ri.is_vec, ri.src2}, {ri.is_vec, ri.src3}};
		vs = '{ri.v_src1, ri.v_src2, ri.v_src3};
		for (int r = 0; r < `TPU_NUM_ENTRY; r++) begin
			rs = '{sh_rows[r].src1, sh_rows[r].src2, sh_rows[r].src3};
			rv = '{sh_rows[r].v_src1, sh_rows[r].v_src2, sh_rows[r].v_src3};
			if (ri.v_dst && sh_rows[r].v_dst && sh_rows[r].dst == d)
				h.waw = 1'b1;
			for (int j = 0; j < 3; j++) begin
				if (ri.v_dst && rv[j] && rs[j] == d)
					h.war = 1'b1;
				if (vs[j] && sh_rows[r].v_dst && sh_rows[r].dst == s[j])
					h.raw = 1'b1;
				for (int k = 0; k < 3; k++)
					if (ri.slice && sh_rows[r].slice && vs[j] && rv[k] && rs[k] == s[j])
						h.rar = 1'b1;
			end
		end
		stall = req && (h.raw || h.war || h.waw || sh_count == `TPU_NUM_ENTRY);
		return h;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	always @(posedge clock) begin
		hazard_t	h;
		logic		stall;
		logic		accept;
		logic		retire;
		if (reset) begin
			for (int r = 0; r < `TPU_NUM_ENTRY; r++) begin
				sh_rows[r] = '0;
				sh_busy[r] = 1'b0;
			end
			sh_wr = '0;
			sh_rd = '0;
			sh_count = 0;
			exp_issue = 1'b0;
			exp_issue_instr = '0;
			exp_hazard = '0;
		end else begin
			h = ref_check(i_req, i_instr, stall);
			check_value("stall", stall, i_stall);
			check_value("issue", exp_issue, i_issue);
			if (exp_issue)
				check_value("issue_instr", exp_issue_instr, i_issue_instr);
			check_value("hazard", exp_hazard, i_hazard);
			check_value("rd_ptr", sh_rd, i_rd_ptr);

			accept = i_req && !stall;
			retire = (sh_count != 0) && !row_live(sh_rd);	// Uses rows before this edge
			exp_hazard = i_req ? h : '0;
			exp_issue = accept;
			if (accept) begin
				exp_issue_instr.instr = i_instr;
				exp_issue_instr.issue_no = sh_wr;
			end
			if (i_commit) begin
				{sh_rows[i_commit_no].v_dst, sh_rows[i_commit_no].v_src1,
					sh_rows[i_commit_no].v_src2, sh_rows[i_commit_no].v_src3} = '0;
				sh_busy[i_commit_no] = 1'b0;
			end
			if (accept) begin
				sh_rows[sh_wr] = '{v_dst: i_instr.v_dst, v_src1: i_instr.v_src1,
					v_src2: i_instr.v_src2, v_src3: i_instr.v_src3, slice: i_instr.slice,
					dst: {i_instr.is_vec, i_instr.dst}, src1: {i_instr.is_vec, i_instr.src1},
					src2: {i_instr.is_vec, i_instr.src2}, src3: {i_instr.is_vec, i_instr.src3}};
				sh_busy[sh_wr] = !(i_instr.v_dst || i_instr.v_src1 || i_instr.v_src2
					|| i_instr.v_src3);
				sh_wr = sh_wr + 1'b1;
			end
			if (retire)
				sh_rd = sh_rd + 1'b1;
			sh_count = sh_count + int'(accept) - int'(retire);
		end
	end

endmodule

/* tb/tpu_issue_tb.sv */
`timescale 1ns/1ps
`include "tpu_issue_defs.svh"

module tpu_issue_tb
	import tpu_issue_pkg::*;
();

	localparam int		N_REQ		= 3000;
	localparam longint	TIMEOUT_NS	= longint'(N_REQ) * 40 * 10;

	logic		clock;
	logic		reset;
	logic		i_req;
	instr_t		i_instr;
	logic		i_commit;
	issue_no_t	i_commit_no;
	logic		o_stall;
	logic		o_issue;
	issue_t		o_issue_instr;
	hazard_t	o_hazard;
	issue_no_t	o_rd_ptr;
	logic		commit_hold;
	issue_no_t	pending [$];	// Issued and not yet committed
	int			n_checks;
	int			n_errors;

	tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

	tpu_issue_top dut (
		.clock(clock), .reset(reset), .i_req(i_req), .i_instr(i_instr),
		.i_commit(i_commit), .i_commit_no(i_commit_no), .o_stall(o_stall),
		.o_issue(o_issue), .o_issue_instr(o_issue_instr), .o_hazard(o_hazard),
		.o_rd_ptr(o_rd_ptr)
	);

	tpu_issue_checker u_checker (
		.clock(clock), .reset(reset), .i_req(i_req), .i_instr(i_instr),
		.i_commit(i_commit), .i_commit_no(i_commit_no), .i_stall(o_stall),
		.i_issue(o_issue), .i_issue_instr(o_issue_instr), .i_hazard(o_hazard),
		.i_rd_ptr(o_rd_ptr), .o_checks(n_checks), .o_errors(n_errors)
	);

	bind tpu_issue_top tpu_issue_asserts u_asserts (
		.clock(clock), .reset(reset), .i_req(i_req), .i_instr(i_instr),
		.i_stall(o_stall), .i_issue(o_issue)
	);

	function automatic instr_t rand_instr();
		instr_t	instr;
		instr.is_vec	= 1'($urandom);
		instr.slice		= 1'($urandom);
		instr.slice_len	= slen_t'($urandom_range(2 ** `TPU_SLEN_W - 1, 0));
		instr.v_dst		= ($urandom % 4) != 0;
		instr.v_src1	= 1'($urandom);
		instr.v_src2	= 1'($urandom);
		instr.v_src3	= ($urandom % 4) == 0;
		instr.dst		= index_t'($urandom_range(5, 0));	// Small range keeps hazards frequent
		instr.src1		= index_t'($urandom_range(5, 0));
		instr.src2		= index_t'($urandom_range(5, 0));
		instr.src3		= index_t'($urandom_range(5, 0));
		instr.imm		= `TPU_IMM_W'($urandom);
		return instr;
	endfunction

	// Called at a rising edge and returns at the accepting edge
	task automatic send_request(input instr_t instr);
		i_req <= 1'b1;
		i_instr <= instr;
		@(posedge clock);
		while (o_stall)
			@(posedge clock);
	endtask

	// Commits issued numbers after random delays and in random order
	always @(posedge clock) begin
		int idx;
		if (reset) begin
			pending.delete();
			i_commit <= 1'b0;
		end else begin
			if (o_issue)
				pending.push_back(o_issue_instr.issue_no);
			i_commit <= 1'b0;
			if (!commit_hold && pending.size() != 0 && ($urandom % 2) == 0) begin
				idx = $urandom_range(pending.size() - 1, 0);
				i_commit <= 1'b1;
				i_commit_no <= pending[idx];
				pending.delete(idx);
			end
		end
	end

	initial begin
		instr_t	instr;
		int		total;
		void'($urandom(32'hd3ea309a));
		i_req = 1'b0;
		i_instr = '0;
		i_commit = 1'b0;
		i_commit_no = '0;
		commit_hold = 1'b1;
		@(posedge clock);
		while (reset)
			@(posedge clock);

		// Fill every row with operand-free instructions while commits are held
		repeat (`TPU_NUM_ENTRY) begin
			instr = rand_instr();
			{instr.v_dst, instr.v_src1, instr.v_src2, instr.v_src3} = '0;
			send_request(instr);
		end
		i_req <= 1'b1;
		i_instr <= rand_instr();
		repeat (20) @(posedge clock);	// Table full so the stall holds
		commit_hold <= 1'b0;
		while (o_stall)
			@(posedge clock);

		for (int n = 0; n < N_REQ; n++) begin
			if (($urandom % 4) == 0) begin
				i_req <= 1'b0;
				repeat ($urandom_range(3, 1)) @(posedge clock);
			end
			send_request(rand_instr());
		end
		i_req <= 1'b0;
		repeat (2) @(posedge clock);
		while (pending.size() != 0)
			@(posedge clock);
		repeat (2 * `TPU_NUM_ENTRY) @(posedge clock);	// Let retirement drain

		total = n_errors + dut.u_asserts.fail_count;
		$display("Checks %0d, value errors %0d, assertion failures %0d",
			n_checks, n_errors, dut.u_asserts.fail_count);
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns before the test sequence finished", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule
